// ==== common/life_pkg.sv ====
// Grid geometry and row types for the 16 x 16 toroidal life engine
// Imported by every RTL block that moves or stores cell rows

package life_pkg;

	////////////////////////////////////////////////////////////
	// Geometry
	////////////////////////////////////////////////////////////

	// Grid is fixed at 16 x 16, one row per memory word
	localparam int grid_width  = 16; // Columns, one bit per cell
	localparam int grid_height = 16; // Rows, top wraps to bottom
	localparam int row_bits    = 4;  // Row address width
	localparam int count_bits  = 16; // Generation counter width

	////////////////////////////////////////////////////////////
	// Row and counter types
	////////////////////////////////////////////////////////////

	// One full row of cells
	// Bit 0 is column 0, bit 15 is column 15
	// Column 15 sits next to column 0 on the torus
	typedef logic [grid_width-1:0] row_t;

	// Row index, wraps naturally at the grid edge
	typedef logic [row_bits-1:0] row_addr_t;

	// Generations since reset, rolls over silently
	typedef logic [count_bits-1:0] count_t;

endpackage

// ==== common/ctrl_pkg.sv ====
// Host command codes, sequencer states, read tags and the seed LFSR
// Shared by the sequencer, the row bus and the engine

package ctrl_pkg;

	// Host opcodes, sampled with req
	typedef enum logic [1:0] {
		cmd_seed, // Fill grid from LFSR
		cmd_load, // Write one host row
		cmd_step, // One generation
		cmd_peek  // Read one row back
	} cmd_e;

	// Tag that travels with every read and comes back with the data
	typedef enum logic [1:0] {
		rd_none,  // No read returned
		rd_prime, // Window fill, no write back
		rd_step,  // Window shift plus write back
		rd_peek   // Host read
	} rd_kind_e;

	typedef enum logic [2:0] {
		st_idle, st_seed, st_load, st_step, st_drain, st_peek, st_ack
	} seq_state_e;

	////////////////////////////////////////////////////////////
	// Step pipeline and seed LFSR
	////////////////////////////////////////////////////////////

	localparam int step_reads   = 18; // Row 15, rows 0..15, row 0
	localparam int drain_cycles = 2;  // Last return plus last write

	localparam int lfsr_width = 16;
	localparam logic [lfsr_width-1:0] lfsr_reset = 16'hACE1;
	localparam logic [lfsr_width-1:0] lfsr_taps  = 16'h002D; // Taps 16 14 13 11

	// Fibonacci step, shift right, feedback into MSB
	function automatic logic [lfsr_width-1:0] lfsr_next(input logic [lfsr_width-1:0] cur);
		return {^(cur & lfsr_taps), cur[lfsr_width-1:1]};
	endfunction

endpackage

// ==== common/row_bus_if.sv ====
// Row bus between sequencer, cell store and row engine
// Reads return one cycle after rd_en, writes land at the clock edge

interface row_bus_if
	import life_pkg::*, ctrl_pkg::*;
();

	logic      bank;                    // Live bank, other bank takes next gen

	logic      rd_en;                   // Read request from sequencer
	row_addr_t rd_addr;
	rd_kind_e  rd_kind;                 // Tag echoed with the data

	logic      rd_valid;                // Return, one cycle after rd_en
	row_t      rd_data;
	row_addr_t rd_row;                  // Echo of rd_addr
	rd_kind_e  rd_echo_kind;            // Echo of rd_kind

	logic      load_en;                 // Host or seed write, live bank
	row_addr_t load_addr;
	row_t      load_data;

	logic      next_en;                 // Engine write, other bank
	row_addr_t next_addr;
	row_t      next_data;

	modport seq (
		output bank, rd_en, rd_addr, rd_kind, load_en, load_addr, load_data,
		input  rd_valid, rd_data, rd_echo_kind
	);

	modport store (
		input  bank, rd_en, rd_addr, rd_kind, load_en, load_addr, load_data,
		input  next_en, next_addr, next_data,
		output rd_valid, rd_data, rd_row, rd_echo_kind
	);

	modport engine (
		input  rd_valid, rd_data, rd_row, rd_echo_kind,
		output next_en, next_addr, next_data
	);

endinterface

// ==== engine/life_row_engine.sv ====
// Next-generation engine, fed one row per cycle by the cell store
// Keeps a three-row window and writes the middle row's next state

module life_row_engine
	import life_pkg::*, ctrl_pkg::*;
(
	input  logic      clk4,
	input  logic      reset,
	row_bus_if.engine bus
);

	// Bit c of result holds column c-1, wraps at column 0
	function automatic row_t west_of(input row_t r);
		return {r[grid_width-2:0], r[grid_width-1]};
	endfunction

	// Bit c of result holds column c+1, wraps at column 15
	function automatic row_t east_of(input row_t r);
		return {r[0], r[grid_width-1:1]};
	endfunction

	////////////////////////////////////////////////////////////
	// Three-row window
	////////////////////////////////////////////////////////////

	row_t      win_top;   // Row above the middle
	row_t      win_mid;   // Row being evolved
	row_t      win_bot;   // Row just returned
	logic      shift_in;  // Prime or step return this cycle
	logic      write_out; // Step return, middle row complete after shift

	assign shift_in  = bus.rd_valid &&
		(bus.rd_echo_kind == rd_prime || bus.rd_echo_kind == rd_step);
	assign write_out = bus.rd_valid && bus.rd_echo_kind == rd_step;

	// Window rows are payload only
	always_ff @(posedge clk4) begin
		if (shift_in) begin
			win_top <= win_mid;
			win_mid <= win_bot;
			win_bot <= bus.rd_data;
			bus.next_addr <= bus.rd_row - 1'b1; // Middle row, wraps 0 to 15
		end
	end

	// Write strobe trails the return by one cycle
	always_ff @(posedge clk4) begin
		if (reset) begin
			bus.next_en <= 1'b0;
		end else begin
			bus.next_en <= write_out;
		end
	end

	////////////////////////////////////////////////////////////
	// Neighbour count and rule
	////////////////////////////////////////////////////////////

	row_t top_w, top_e, mid_w, mid_e, bot_w, bot_e;
	logic [3:0] ncount [grid_width]; // 0..8 live neighbours per cell
	row_t next_row;

	assign top_w = west_of(win_top);
	assign top_e = east_of(win_top);
	assign mid_w = west_of(win_mid);
	assign mid_e = east_of(win_mid);
	assign bot_w = west_of(win_bot);
	assign bot_e = east_of(win_bot);

	always_comb begin
		for (int c = 0; c < grid_width; c++) begin
			// Eight neighbours, the cell itself excluded
			ncount[c] = 4'(top_w[c]) + 4'(win_top[c]) + 4'(top_e[c])
				+ 4'(mid_w[c]) + 4'(mid_e[c])
				+ 4'(bot_w[c]) + 4'(win_bot[c]) + 4'(bot_e[c]);
			// Born on 3, survives on 2 or 3
			next_row[c] = (ncount[c] == 4'd3) || (win_mid[c] && ncount[c] == 4'd2);
		end
	end

	assign bus.next_data = next_row; // Valid while next_en is high

endmodule

// ==== source/life_sequencer.sv ====
// Command FSM for the life engine: handshake, read sequencing, seeding
// Owns the live bank bit, the seed LFSR and the generation counter

module life_sequencer
	import life_pkg::*, ctrl_pkg::*;
(
	input  logic      clk4,
	input  logic      reset,
	input  logic      req,
	input  cmd_e      cmd,
	input  row_addr_t row_sel,
	input  row_t      load_data,
	output logic      ack,
	output row_t      row_data,
	output count_t    gen_count,
	row_bus_if.seq    bus
);

	seq_state_e state;
	logic [4:0] cnt;      // Read, seed and drain counter
	row_addr_t  row_q;    // Row captured with the command
	row_t       data_q;   // Load data captured with the command
	row_t       lfsr;
	row_t       seed_row; // Next LFSR value, written and kept
	logic       peek_back;

	assign seed_row  = lfsr_next(lfsr);
	assign peek_back = bus.rd_valid && bus.rd_echo_kind == rd_peek;

	////////////////////////////////////////////////////////////
	// Command FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk4) begin
		if (reset) begin
			state     <= st_idle;
			cnt       <= '0;
			ack       <= 1'b0;
			bus.bank  <= 1'b0;
			gen_count <= '0;
			lfsr      <= lfsr_reset;
		end else begin
			case (state)
				st_idle: begin
					// ack is low here, so req alone starts a command
					if (req) begin
						cnt <= '0;
						case (cmd)
							cmd_seed: state <= st_seed;
							cmd_load: state <= st_load;
							cmd_step: state <= st_step;
							cmd_peek: state <= st_peek;
							default:  state <= st_idle;
						endcase
					end
				end
				st_seed: begin
					lfsr <= seed_row; // One advance per row
					cnt  <= cnt + 1'b1;
					if (cnt == 5'(grid_height - 1)) begin
						ack   <= 1'b1;
						state <= st_ack;
					end
				end
				st_load: begin
					ack   <= 1'b1; // Row written this cycle
					state <= st_ack;
				end
				st_step: begin
					cnt <= cnt + 1'b1;
					if (cnt == 5'(step_reads - 1)) begin
						cnt   <= '0;
						state <= st_drain;
					end
				end
				st_drain: begin
					cnt <= cnt + 1'b1;
					// Last engine write lands on this edge, safe to flip
					if (cnt == 5'(drain_cycles - 1)) begin
						bus.bank  <= !bus.bank;
						gen_count <= gen_count + 1'b1;
						ack       <= 1'b1;
						state     <= st_ack;
					end
				end
				st_peek: begin
					cnt <= 5'd1; // Single read issued on first cycle
					if (peek_back) begin
						ack   <= 1'b1;
						state <= st_ack;
					end
				end
				st_ack: begin
					// Hold until host lets go of req
					if (!req) begin
						ack   <= 1'b0;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Command payload and peek result
	always_ff @(posedge clk4) begin
		if (state == st_idle && req) begin
			row_q  <= row_sel;
			data_q <= load_data;
		end
		if (peek_back) begin
			row_data <= bus.rd_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Row bus requests
	////////////////////////////////////////////////////////////

	always_comb begin
		bus.rd_en     = 1'b0;
		bus.rd_addr   = row_q;
		bus.rd_kind   = rd_none;
		bus.load_en   = 1'b0;
		bus.load_addr = row_q;
		bus.load_data = data_q;
		case (state)
			st_step: begin
				bus.rd_en   = 1'b1;
				bus.rd_addr = row_addr_t'(cnt - 1'b1); // 15, 0..15, 0
				bus.rd_kind = (cnt < 5'd2) ? rd_prime : rd_step;
			end
			st_peek: begin
				bus.rd_en   = (cnt == 5'd0);
				bus.rd_kind = rd_peek;
			end
			st_seed: begin
				bus.load_en   = 1'b1;
				bus.load_addr = row_addr_t'(cnt);
				bus.load_data = seed_row;
			end
			st_load: bus.load_en = 1'b1;
			default: ;
		endcase
	end

endmodule

// ==== source/cell_store.sv ====
// Two-bank row memory for the life grid
// Reads and host loads use the live bank, engine writes go to the other one

module cell_store
	import life_pkg::*, ctrl_pkg::*;
(
	input  logic     clk4,
	input  logic     reset,
	row_bus_if.store bus
);

	row_t mem [2][grid_height]; // Bank, row

	////////////////////////////////////////////////////////////
	// Write ports
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk4) begin
		if (bus.load_en) begin
			mem[bus.bank][bus.load_addr] <= bus.load_data; // Host or seed row
		end
		if (bus.next_en) begin
			mem[!bus.bank][bus.next_addr] <= bus.next_data; // Next generation
		end
	end

	////////////////////////////////////////////////////////////
	// Read port, one cycle latency
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk4) begin
		bus.rd_data <= mem[bus.bank][bus.rd_addr];
		bus.rd_row  <= bus.rd_addr; // Engine derives its write row from this
	end

	// Strobe and tag
	always_ff @(posedge clk4) begin
		if (reset) begin
			bus.rd_valid     <= 1'b0;
			bus.rd_echo_kind <= rd_none;
		end else begin
			bus.rd_valid     <= bus.rd_en;
			bus.rd_echo_kind <= bus.rd_en ? bus.rd_kind : rd_none;
		end
	end

endmodule

// ==== source/life_top.sv ====
// Top level of the life engine, host req/ack port on plain wires
// Joins sequencer, cell store and row engine through one row bus

module life_top
	import life_pkg::*, ctrl_pkg::*;
(
	input  logic      clk4,
	input  logic      reset,

	// Host command side
	input  logic      req,       // Four-phase request
	input  cmd_e      cmd,
	input  row_addr_t row_sel,   // Row for load and peek
	input  row_t      load_data,

	// Host response side
	output logic      ack,
	output row_t      row_data,  // Peek result, valid with ack
	output count_t    gen_count
);

	////////////////////////////////////////////////////////////
	// Row bus and blocks
	////////////////////////////////////////////////////////////

	row_bus_if bus ();

	// Producer, owns handshake and bank
	life_sequencer u_seq (
		.clk4      (clk4),
		.reset     (reset),
		.req       (req),
		.cmd       (cmd),
		.row_sel   (row_sel),
		.load_data (load_data),
		.ack       (ack),
		.row_data  (row_data),
		.gen_count (gen_count),
		.bus       (bus.seq)
	);

	// Two-bank row memory
	cell_store u_store (
		.clk4  (clk4),
		.reset (reset),
		.bus   (bus.store)
	);

	// Rule and write back
	life_row_engine u_engine (
		.clk4  (clk4),
		.reset (reset),
		.bus   (bus.engine)
	);

endmodule

// ==== tests/life_model.svh ====
// Shadow grid, life rule and seed LFSR that predict what the DUT returns
// Included inside the testbench module, life_pkg and ctrl_pkg must be in scope
`ifndef LIFE_MODEL_SVH
`define LIFE_MODEL_SVH

row_t        shadow [grid_height]; // Expected live bank contents
logic [15:0] seed_state;           // Mirror of the DUT LFSR
count_t      gens;                 // Expected gen_count

// Fibonacci LFSR, taps 16 14 13 11 are bits 0 2 3 5 when shifting right
function automatic logic [15:0] lfsr_advance(input logic [15:0] cur);
	logic fb;
	fb = cur[0] ^ cur[2] ^ cur[3] ^ cur[5];
	return {fb, cur[15:1]}; // Feedback into MSB
endfunction

// Cell lookup with wrap on both axes
function automatic logic cell_alive(input int r, input int c);
	return shadow[(r + grid_height) % grid_height][(c + grid_width) % grid_width];
endfunction

function automatic int count_neighbours(input int r, input int c);
	int n;
	n = 0;
	for (int dr = -1; dr <= 1; dr++) begin
		for (int dc = -1; dc <= 1; dc++) begin
			if (dr != 0 || dc != 0)
				n += cell_alive(r + dr, c + dc); // Self excluded
		end
	end
	return n;
endfunction

// One generation over the whole torus
function automatic void evolve_shadow();
	row_t nxt [grid_height];
	int   n;
	for (int r = 0; r < grid_height; r++) begin
		for (int c = 0; c < grid_width; c++) begin
			n = count_neighbours(r, c);
			nxt[r][c] = (n == 3) || (shadow[r][c] && n == 2); // Birth 3, survive 2 or 3
		end
	end
	shadow = nxt;
	gens++;
endfunction

// Seed fills rows 0..15 in order, one LFSR advance per row
function automatic void seed_shadow();
	for (int r = 0; r < grid_height; r++) begin
		seed_state = lfsr_advance(seed_state);
		shadow[r]  = seed_state;
	end
endfunction

function automatic void reset_shadow();
	seed_state = lfsr_reset;
	gens       = '0;
endfunction

`endif

// ==== tests/life_tb.sv ====
// Directed testbench for the life engine with every command sent over req/ack
// Top module life_tb as listed in build.f

module life_tb
	import life_pkg::*, ctrl_pkg::*;
();

	localparam int num_cmds  = 300;                // Upper bound over all tests
	localparam int cyc_limit = num_cmds * 40 + 500; // Plus reset margin

	logic      clk4;
	logic      reset;
	logic      req;
	cmd_e      cmd;
	row_addr_t row_sel;
	row_t      load_data;
	logic      ack;
	row_t      row_data;
	count_t    gen_count;

	int   errors, checks, tests, cycles;
	logic prev_req, prev_ack; // Values seen at the previous falling edge

	`include "life_model.svh"

	life_top dut_i (.*);

	initial begin
		clk4 = 1'b0;
		forever #4 clk4 = ~clk4;
	end

	// Hang guard
	initial begin
		cycles = 0;
		while (cycles < cyc_limit) begin
			@(posedge clk4);
			cycles++;
		end
		$display("Timeout after %0d cycles, the DUT never finished a command", cycles);
		$display("Simulation failed");
		$finish;
	end

	// ack may only rise on an edge where req was high
	always @(negedge clk4) begin
		if (!reset && ack && !prev_ack) begin
			assert (prev_req) else begin
				$display("[FAIL] %0t: ack rose while req was low", $time);
				errors++;
			end
		end
		prev_req = req;
		prev_ack = ack;
	end

	//////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////

	task automatic expect_value(input string what, input row_t got, input row_t want);
		checks++;
		assert (got === want) else begin
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, want);
			errors++;
		end
	endtask

	task automatic expect_ack(input logic want, input string why);
		checks++;
		assert (ack === want) else begin
			$display("[FAIL] %0t: %s", $time, why);
			errors++;
		end
	endtask

	// Four-phase transfer with req held for extra cycles after ack
	task automatic do_cmd(input cmd_e c, input row_addr_t r, input row_t d, input int hold);
		@(posedge clk4);
		cmd       <= c;
		row_sel   <= r;
		load_data <= d;
		req       <= 1'b1;
		do begin
			@(negedge clk4);
		end while (!ack);
		repeat (hold) begin
			@(negedge clk4);
			expect_ack(1'b1, "ack fell before req was dropped");
		end
		@(posedge clk4);
		req <= 1'b0;
		@(negedge clk4);
		expect_ack(1'b1, "ack fell before the DUT could see req low");
		@(negedge clk4);
		expect_ack(1'b0, "ack still high one cycle after req fell");
	endtask

	task automatic load_grid();
		for (int r = 0; r < grid_height; r++)
			do_cmd(cmd_load, row_addr_t'(r), shadow[r], 0);
	endtask

	task automatic peek_grid(input string what);
		for (int r = 0; r < grid_height; r++) begin
			do_cmd(cmd_peek, row_addr_t'(r), '0, 0);
			expect_value($sformatf("%s row %0d", what, r), row_data, shadow[r]);
		end
		expect_value({what, " gen_count"}, gen_count, gens);
	endtask

	task automatic step_once(input int hold);
		do_cmd(cmd_step, '0, '0, hold);
		evolve_shadow();
	endtask

	task automatic apply_reset();
		@(posedge clk4);
		reset <= 1'b1;
		repeat (10) @(posedge clk4);
		reset <= 1'b0;
		reset_shadow();
	endtask

	task automatic report(input string name, input int errs_before);
		tests++;
		$display("%s: %s", name, (errors == errs_before) ? "PASS" : "FAIL");
	endtask

	//////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////

	task automatic test_load_peek();
		int e0;
		e0 = errors;
		for (int r = 0; r < grid_height; r++)
			shadow[r] = row_t'($urandom);
		load_grid();
		peek_grid("load_peek"); // gen_count still 0
		report("test_load_peek", e0);
	endtask

	// Blinker rows written out by hand
	task automatic test_blinker();
		int e0;
		e0 = errors;
		shadow    = '{default: '0};
		shadow[7] = 16'h01C0; // Columns 6..8
		load_grid();
		do_cmd(cmd_step, '0, '0, 0);
		shadow    = '{default: '0};
		shadow[6] = 16'h0080;
		shadow[7] = 16'h0080;
		shadow[8] = 16'h0080;
		gens++;
		peek_grid("blinker vertical");
		do_cmd(cmd_step, '0, '0, 0);
		shadow    = '{default: '0};
		shadow[7] = 16'h01C0;
		gens++;
		peek_grid("blinker back"); // gen_count 2
		report("test_blinker", e0);
	endtask

	// South-east glider at the corner that crosses both edges
	task automatic test_glider();
		int e0;
		e0 = errors;
		shadow     = '{default: '0};
		shadow[13] = 16'h4000;
		shadow[14] = 16'h8000;
		shadow[15] = 16'hE000;
		load_grid();
		repeat (8) begin
			step_once(0);
			peek_grid("glider");
		end
		report("test_glider", e0);
	endtask

	task automatic test_seed();
		int e0;
		int n;
		e0 = errors;
		apply_reset(); // LFSR back to its reset value
		do_cmd(cmd_seed, '0, '0, 0);
		seed_shadow();
		peek_grid("seed");
		n = $urandom_range(4, 1);
		repeat (n)
			step_once(0);
		peek_grid("seed steps");
		report("test_seed", e0);
	endtask

	// Random late release of req on every transfer
	task automatic test_handshake();
		int        e0;
		row_addr_t r;
		e0 = errors;
		for (int i = 0; i < 4; i++) begin
			r         = row_addr_t'($urandom);
			shadow[r] = row_t'($urandom);
			do_cmd(cmd_load, r, shadow[r], $urandom_range(5, 0));
			do_cmd(cmd_peek, r, '0, $urandom_range(5, 0));
			expect_value("handshake peek", row_data, shadow[r]);
		end
		step_once($urandom_range(5, 0));
		peek_grid("handshake step");
		report("test_handshake", e0);
	endtask

	initial begin
		void'($urandom(47));
		errors = 0;
		checks = 0;
		tests  = 0;
		req       <= 1'b0;
		cmd       <= cmd_seed;
		row_sel   <= '0;
		load_data <= '0;
		reset     <= 1'b1;
		apply_reset();
		test_load_peek();
		test_blinker();
		test_glider();
		test_seed();
		test_handshake();
		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+tests
common/life_pkg.sv
common/ctrl_pkg.sv
common/row_bus_if.sv
engine/life_row_engine.sv
source/life_sequencer.sv
source/cell_store.sv
source/life_top.sv
tests/life_tb.sv

// ==== Bender.yml ====
package:
  name: life_engine

sources:
  - files:
      - common/life_pkg.sv
      - common/ctrl_pkg.sv
      - common/row_bus_if.sv
      - engine/life_row_engine.sv
      - source/life_sequencer.sv
      - source/cell_store.sv
      - source/life_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/life_tb.sv
